// ==== hdl/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Byte address of the first program word
`define CORE_START_ADDR 32'h80020000

`define CORE_MEM_WORDS 256

// Power of two, at least 2
`define CORE_QUEUE_DEPTH 4

`endif

// ==== hdl/execute_unit.sv ====
module execute_unit (
	input  logic clock,
	input  logic reset,
	input  logic pop_valid,
	input  mips_mem_pkg::word_t pop_word,
	output logic pop_take,
	output logic retire_valid,
	output mips_isa_pkg::reg_index_t retire_reg,
	output mips_mem_pkg::word_t retire_data,
	input  logic retire_ready
);
	import mips_isa_pkg::*;
	import mips_mem_pkg::*;

	word_t regs [32];
	insn_t insn;
	word_t rs_val;
	word_t rt_val;
	word_t imm_sx;
	word_t imm_zx;
	word_t result;
	reg_index_t dest;

	assign insn = pop_word;

	// r0 always reads zero
	assign rs_val = (insn.r.rs == '0) ? '0 : regs[insn.r.rs];
	assign rt_val = (insn.r.rt == '0) ? '0 : regs[insn.r.rt];
	assign imm_sx = {{16{insn.i.imm[15]}}, insn.i.imm};
	assign imm_zx = {16'b0, insn.i.imm};

	// Retire slot free or draining this cycle
	assign pop_take = pop_valid && (!retire_valid || retire_ready);

	always_comb begin
		result = '0;
		if (insn.r.opcode == RTYPE) begin
			dest = insn.r.rd;
			case (insn.r.funct)
				ADD, ADDU: result = rs_val + rt_val;
				SUB, SUBU: result = rs_val - rt_val;
				AND: result = rs_val & rt_val;
				OR: result = rs_val | rt_val;
				XOR: result = rs_val ^ rt_val;
				NOR: result = ~(rs_val | rt_val);
				SLT: result = {31'b0, $signed(rs_val) < $signed(rt_val)};
				SLTU: result = {31'b0, rs_val < rt_val};
				SLL: result = rt_val << insn.r.shamt;
				SRL: result = rt_val >> insn.r.shamt;
				SRA: result = $signed(rt_val) >>> insn.r.shamt;
				default: dest = '0; // Unsupported function
			endcase
		end else begin
			dest = insn.i.rt;
			case (insn.i.opcode)
				ADDI, ADDIU: result = rs_val + imm_sx;
				SLTI: result = {31'b0, $signed(rs_val) < $signed(imm_sx)};
				SLTIU: result = {31'b0, rs_val < imm_sx}; // Unsigned after sign extension
				ORI: result = rs_val | imm_zx;
				XORI: result = rs_val ^ imm_zx;
				LUI: result = {insn.i.imm, 16'b0};
				default: dest = '0;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			retire_valid <= 1'b0;
		end else if (pop_take) begin
			retire_valid <= 1'b1;
		end else if (retire_ready) begin
			retire_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (pop_take) begin
			retire_reg <= dest;
			retire_data <= result;
		end
	end

	// Write lands with retire_valid, next instruction sees it
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (pop_take && dest != '0) begin
			regs[dest] <= result;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		retire_valid && !retire_ready |=>
			retire_valid && $stable(retire_reg) && $stable(retire_data))
		else $error("execute_unit: retire changed while stalled");

endmodule

// ==== hdl/fetch_unit.sv ====
`include "core_settings.svh"

module fetch_unit (
	input  logic clock,
	input  logic reset,
	input  logic run,
	output logic fetch_req,
	output mips_mem_pkg::byte_addr_t fetch_addr,
	input  logic fetch_grant,
	input  logic fetch_valid,
	input  mips_mem_pkg::word_t fetch_data,
	input  logic queue_room,
	output logic push_valid,
	output mips_mem_pkg::word_t push_word
);
	import mips_mem_pkg::*;

	localparam byte_addr_t last_addr = `CORE_START_ADDR + 4 * (`CORE_MEM_WORDS - 1);

	logic at_end;

	assign fetch_req = run && queue_room && !at_end;

	// fetch_addr is the program counter
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_addr <= `CORE_START_ADDR;
			at_end <= 1'b0;
			push_valid <= 1'b0;
		end else begin
			push_valid <= fetch_valid;
			if (fetch_grant) begin
				if (fetch_addr == last_addr)
					at_end <= 1'b1; // Stays put until reset
				else
					fetch_addr <= fetch_addr + 32'd4;
			end
		end
	end

	always_ff @(posedge clock) begin
		push_word <= fetch_data;
	end

endmodule

// ==== hdl/insn_queue.sv ====
`include "core_settings.svh"

module insn_queue (
	input  logic clock,
	input  logic reset,
	input  logic push_valid,
	input  mips_mem_pkg::word_t push_word,
	output logic queue_room,
	output logic pop_valid,
	output mips_mem_pkg::word_t pop_word,
	input  logic pop_take
);
	import mips_mem_pkg::*;

	localparam int ptr_w = $clog2(`CORE_QUEUE_DEPTH);

	word_t entries [`CORE_QUEUE_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;
	logic [ptr_w:0] occupied;

	// Word being pushed counts as taken, the other in-flight word needs the spare slot
	assign occupied = count + push_valid;
	assign queue_room = occupied <= (`CORE_QUEUE_DEPTH - 2);
	assign pop_valid = count != 0;
	assign pop_word = entries[rd_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_valid)
				wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two
			if (pop_take)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_valid, pop_take})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push_valid)
			entries[wr_ptr] <= push_word;
	end

	// Fetch flow control must keep the queue from overflowing
	assert property (@(posedge clock) disable iff (reset)
		push_valid |-> count < `CORE_QUEUE_DEPTH)
		else $error("insn_queue: push while full");

	assert property (@(posedge clock) disable iff (reset)
		pop_take |-> pop_valid)
		else $error("insn_queue: pop while empty");

endmodule

// ==== hdl/mips_core.sv ====
module mips_core (
	input  logic clock,
	input  logic reset,
	input  logic run,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  mips_mem_pkg::byte_addr_t wb_adr,
	input  mips_mem_pkg::word_t wb_dat_w,
	output logic wb_ack,
	output mips_mem_pkg::word_t wb_dat_r,
	output logic retire_valid,
	output mips_isa_pkg::reg_index_t retire_reg,
	output mips_mem_pkg::word_t retire_data,
	input  logic retire_ready
);
	import mips_mem_pkg::*;

	logic fetch_req;
	logic fetch_grant;
	logic fetch_valid;
	byte_addr_t fetch_addr;
	word_t fetch_data;
	logic queue_room;
	logic push_valid;
	word_t push_word;
	logic pop_valid;
	logic pop_take;
	word_t pop_word;

	program_memory program_memory_i (
		.clock(clock), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_grant(fetch_grant),
		.fetch_valid(fetch_valid), .fetch_data(fetch_data)
	);

	fetch_unit fetch_unit_i (
		.clock(clock), .reset(reset), .run(run),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_grant(fetch_grant),
		.fetch_valid(fetch_valid), .fetch_data(fetch_data), .queue_room(queue_room),
		.push_valid(push_valid), .push_word(push_word)
	);

	insn_queue insn_queue_i (
		.clock(clock), .reset(reset),
		.push_valid(push_valid), .push_word(push_word), .queue_room(queue_room),
		.pop_valid(pop_valid), .pop_word(pop_word), .pop_take(pop_take)
	);

	execute_unit execute_unit_i (
		.clock(clock), .reset(reset),
		.pop_valid(pop_valid), .pop_word(pop_word), .pop_take(pop_take),
		.retire_valid(retire_valid), .retire_reg(retire_reg),
		.retire_data(retire_data), .retire_ready(retire_ready)
	);

endmodule

// ==== hdl/mips_isa_pkg.sv ====
package mips_isa_pkg;

	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] reg_index_t;

	// Opcodes
	localparam opcode_t RTYPE = 6'b000000;
	localparam opcode_t ADDI  = 6'b001000; // No overflow trap
	localparam opcode_t ADDIU = 6'b001001;
	localparam opcode_t SLTI  = 6'b001010;
	localparam opcode_t SLTIU = 6'b001011;
	localparam opcode_t ORI   = 6'b001101;
	localparam opcode_t XORI  = 6'b001110;
	localparam opcode_t LUI   = 6'b001111;

	// R-type function codes
	localparam funct_t SLL  = 6'b000000;
	localparam funct_t SRL  = 6'b000010;
	localparam funct_t SRA  = 6'b000011;
	localparam funct_t ADD  = 6'b100000;
	localparam funct_t ADDU = 6'b100001;
	localparam funct_t SUB  = 6'b100010;
	localparam funct_t SUBU = 6'b100011;
	localparam funct_t AND  = 6'b100100;
	localparam funct_t OR   = 6'b100101;
	localparam funct_t XOR  = 6'b100110;
	localparam funct_t NOR  = 6'b100111;
	localparam funct_t SLT  = 6'b101010;
	localparam funct_t SLTU = 6'b101011;

	typedef struct packed {
		opcode_t opcode;
		reg_index_t rs;
		reg_index_t rt;
		reg_index_t rd;
		logic [4:0] shamt;
		funct_t funct;
	} r_view_t;

	typedef struct packed {
		opcode_t opcode;
		reg_index_t rs;
		reg_index_t rt;
		logic [15:0] imm;
	} i_view_t;

	// Same word, read per opcode
	typedef union packed {
		r_view_t r;
		i_view_t i;
	} insn_t;

endpackage

// ==== hdl/mips_mem_pkg.sv ====
`include "core_settings.svh"

package mips_mem_pkg;

	typedef logic [31:0] word_t;

	// Byte address as seen on the bus and fetch ports
	typedef logic [31:0] byte_addr_t;

	typedef logic [$clog2(`CORE_MEM_WORDS)-1:0] mem_index_t;

endpackage

// ==== hdl/program_memory.sv ====
`include "core_settings.svh"

module program_memory (
	input  logic clock,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  mips_mem_pkg::byte_addr_t wb_adr,
	input  mips_mem_pkg::word_t wb_dat_w,
	output logic wb_ack,
	output mips_mem_pkg::word_t wb_dat_r,
	input  logic fetch_req,
	input  mips_mem_pkg::byte_addr_t fetch_addr,
	output logic fetch_grant,
	output logic fetch_valid,
	output mips_mem_pkg::word_t fetch_data
);
	import mips_mem_pkg::*;

	word_t mem [`CORE_MEM_WORDS];
	logic wb_access;
	mem_index_t wb_index;
	mem_index_t fetch_index;

	// Offset from start address, in words, wrapped to the array size
	function automatic mem_index_t word_index(byte_addr_t addr);
		byte_addr_t offset;
		offset = addr - `CORE_START_ADDR;
		return offset[$bits(mem_index_t)+1:2];
	endfunction

	assign wb_access = wb_cyc && wb_stb && !wb_ack; // Once per strobe
	assign wb_index = word_index(wb_adr);
	assign fetch_index = word_index(fetch_addr);
	assign fetch_grant = fetch_req && !wb_cyc; // Bus cycle wins

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_ack <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			wb_ack <= wb_access;
			fetch_valid <= fetch_grant;
		end
	end

	// Single port, one access per cycle
	always_ff @(posedge clock) begin
		if (wb_access) begin
			if (wb_we)
				mem[wb_index] <= wb_dat_w;
			else
				wb_dat_r <= mem[wb_index];
		end else if (fetch_grant) begin
			fetch_data <= mem[fetch_index];
		end
	end

endmodule

// ==== mips_core.f ====
+incdir+hdl
hdl/mips_mem_pkg.sv
hdl/mips_isa_pkg.sv
hdl/program_memory.sv
hdl/fetch_unit.sv
hdl/insn_queue.sv
hdl/execute_unit.sv
hdl/mips_core.sv
testbench/mips_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module mips_core_tb \
	-f mips_core.f -o mips_core_sim \
	&& ./obj_dir/mips_core_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation stopped early"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// ==== testbench/mips_core_tb.sv ====
`include "core_settings.svh"

module mips_core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import mips_isa_pkg::*;

	localparam funct_t r_functs [13] = '{SLL, SRL, SRA, ADD, ADDU, SUB, SUBU,
		AND, OR, XOR, NOR, SLT, SLTU};
	localparam opcode_t i_ops [7] = '{ADDI, ADDIU, SLTI, SLTIU, ORI, XORI, LUI};

	logic clock;
	logic reset = 1'b1;
	logic run = 1'b0;
	logic wb_cyc = 1'b0;
	logic wb_stb = 1'b0;
	logic wb_we = 1'b0;
	logic [31:0] wb_adr = '0;
	logic [31:0] wb_dat_w = '0;
	logic retire_ready = 1'b1;
	logic wb_ack;
	logic [31:0] wb_dat_r;
	logic retire_valid;
	logic [4:0] retire_reg;
	logic [31:0] retire_data;
	logic [31:0] prog [`CORE_MEM_WORDS];
	logic [31:0] model_regs [32];
	logic [1023:0] ready_pattern = '1;
	integer seed = 32'habf5;
	int error_count = 0;
	int retire_count = 0;
	bit timed_out = 1'b0;
	bit stalled = 1'b0;
	logic [4:0] held_reg;
	logic [31:0] held_data;
	logic [36:0] expected;

	mips_core mips_core_i (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Back-pressure from a pattern set per pass
	initial begin
		int step;
		step = 0;
		forever begin
			@(posedge clock);
			retire_ready <= ready_pattern[step % 1024];
			step++;
		end
	end

	task automatic check_value(string what, logic [31:0] got, logic [31:0] want);
		if (got !== want) begin
			error_count++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// Expected {destination, data} from the model register file
	function automatic logic [36:0] expect_retire(logic [31:0] insn);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [4:0] dest;
		logic [31:0] data;
		a = model_regs[insn[25:21]];
		b = model_regs[insn[20:16]];
		sx = {{16{insn[15]}}, insn[15:0]};
		dest = (insn[31:26] == RTYPE) ? insn[15:11] : insn[20:16];
		data = '0;
		if (insn[31:26] == RTYPE) begin
			case (insn[5:0])
				ADD, ADDU: data = a + b;
				SUB, SUBU: data = a - b;
				AND: data = a & b;
				OR: data = a | b;
				XOR: data = a ^ b;
				NOR: data = ~(a | b);
				SLT: data = 32'($signed(a) < $signed(b));
				SLTU: data = 32'(a < b);
				SLL: data = b << insn[10:6];
				SRL: data = b >> insn[10:6];
				SRA: data = $signed(b) >>> insn[10:6];
				default: dest = '0;
			endcase
		end else begin
			case (insn[31:26])
				ADDI, ADDIU: data = a + sx;
				SLTI: data = 32'($signed(a) < $signed(sx));
				SLTIU: data = 32'(a < sx);
				ORI: data = a | {16'h0, insn[15:0]};
				XORI: data = a ^ {16'h0, insn[15:0]};
				LUI: data = {insn[15:0], 16'h0};
				default: dest = '0; // Unsupported opcode
			endcase
		end
		return {dest, data};
	endfunction

	// Compares every completed retire and watches the outputs while stalled
	always @(negedge clock) begin
		if (reset) begin
			retire_count = 0;
			stalled = 1'b0;
			for (int i = 0; i < 32; i++)
				model_regs[i] = '0;
		end else begin
			if (stalled) begin
				check_value("retire_valid while stalled", retire_valid, 1'b1);
				check_value("retire_reg while stalled", retire_reg, held_reg);
				check_value("retire_data while stalled", retire_data, held_data);
			end
			stalled = retire_valid && !retire_ready;
			held_reg = retire_reg;
			held_data = retire_data;
			if (retire_valid && retire_ready) begin
				if (retire_count < `CORE_MEM_WORDS) begin
					expected = expect_retire(prog[retire_count]);
					check_value("retire_reg", retire_reg, expected[36:32]);
					check_value("retire_data", retire_data, expected[31:0]);
					if (expected[36:32] != '0)
						model_regs[expected[36:32]] = expected[31:0];
				end
				retire_count++; // Extras caught by the final count
			end
		end
	end

	task automatic bus_access(logic write, logic [31:0] addr, logic [31:0] data,
		output logic [31:0] rdata);
		int waited;
		@(posedge clock);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= write;
		wb_adr <= addr;
		wb_dat_w <= data;
		waited = 0;
		@(negedge clock);
		while (!wb_ack && waited < 8) begin
			waited++;
			@(negedge clock);
		end
		if (!wb_ack) begin
			$display("Timed out waiting for wb_ack at address %h", addr);
			timed_out = 1'b1;
		end
		check_value("cycles before wb_ack", waited, 1);
		rdata = wb_dat_r;
		@(posedge clock);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		@(negedge clock);
		check_value("wb_ack one cycle later", wb_ack, 1'b0);
	endtask

	// Reset, bus check, program load, then run until every word retires
	task automatic run_pass(bit random_ready);
		logic [31:0] word;
		logic [31:0] got;
		funct_t fn;
		opcode_t op;
		int cycles;
		@(posedge clock);
		reset <= 1'b1;
		run <= 1'b0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("retire_valid after reset", retire_valid, 1'b0);
		check_value("wb_ack after reset", wb_ack, 1'b0);
		word = $random(seed);
		bus_access(1'b1, `CORE_START_ADDR + 32'd148, word, got);
		bus_access(1'b0, `CORE_START_ADDR + 32'd148, '0, got);
		check_value("wb read back", got, word);
		for (int k = 0; k < `CORE_MEM_WORDS; k++) begin
			word = $random(seed);
			fn = r_functs[{$random(seed)} % 13];
			op = i_ops[{$random(seed)} % 7];
			if (k < 62) // LUI then ORI into r1 to r31
				prog[k] = {k[0] ? ORI : LUI, k[0] ? 5'(k / 2 + 1) : 5'd0,
					5'(k / 2 + 1), word[15:0]};
			else if (k < 162)
				prog[k] = {RTYPE, word[25:11], fn[5] ? 5'd0 : word[10:6], fn};
			else if (k < 222) // Every opcode with both immediate signs
				prog[k] = {i_ops[(k / 2) % 7], word[25:16], k[0], word[14:0]};
			else if (k % 4 == 0)
				prog[k] = {RTYPE, word[25:16], 5'd0, 5'd0, fn}; // Writes r0
			else if (k % 4 == 1)
				prog[k] = {RTYPE, 10'd0, word[15:11], 5'd0, fn}; // Reads r0 twice
			else if (k % 4 == 2)
				prog[k] = {op, word[25:21], 5'd0, word[15:0]};
			else
				prog[k] = {2'b10, word[29:0]}; // Load and store opcodes are not kept
			bus_access(1'b1, `CORE_START_ADDR + 32'(4 * k), prog[k], got);
			if (timed_out)
				break;
		end
		for (int c = 0; c < 1024; c++)
			ready_pattern[c] = random_ready ? 1'($random(seed)) : 1'b1;
		@(posedge clock);
		run <= !timed_out;
		cycles = 0;
		while (!timed_out && retire_count < `CORE_MEM_WORDS && cycles < 20000) begin
			@(negedge clock);
			cycles++;
		end
		if (!timed_out && retire_count < `CORE_MEM_WORDS) begin
			$display("Timed out with %0d of %0d instructions retired", retire_count,
				`CORE_MEM_WORDS);
			timed_out = 1'b1;
		end
		for (int c = 0; c < 40; c++)
			@(negedge clock);
		check_value("retire count", retire_count, `CORE_MEM_WORDS);
	endtask

	initial begin
		run_pass(1'b0);
		if (!timed_out)
			run_pass(1'b1);
		$display("Done with %0d errors and %0d timeouts", error_count, timed_out);
		if (error_count == 0 && !timed_out)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
